//--- verilog/pll_cfg_pkg.sv
//************************************************************
// shared widths, DRP address limits, latency and lock constants
// and the response and state enums of the PLL config subsystem
//************************************************************
package pll_cfg_pkg;

	// DRP port geometry
	localparam int drp_addr_w = 7;                  // DRP register address
	localparam int drp_data_w = 16;                 // DRP register data

	// AXI4-Lite side, one DRP register per 32-bit word
	localparam int axi_addr_w = 9;                  // byte address, bits 8:2 pick the register
	localparam int axi_data_w = 32;                 // upper half reads as zero

	localparam logic [drp_addr_w-1:0] drp_last_addr = 7'h4F; // above this is reserved

	// PLL model timing
	localparam int drp_lat_base     = 3;            // ready latency is this plus daddr[1:0]
	localparam int lat_cnt_w        = 3;            // holds latency minus two, up to 4
	localparam int lock_hold_cycles = 20;           // locked low after reset and each write
	localparam int lock_cnt_w       = 5;            // holds lock_hold_cycles-1

	// AXI response codes
	typedef enum logic [1:0] {
		okay   = 2'b00,
		slverr = 2'b10
	} axi_resp_e;

	// bridge FSM
	typedef enum logic [2:0] {
		bs_idle,                                    // waiting for an AXI address
		bs_req_clr,                                 // go is up, waiting for done to drop
		bs_req_done,                                // waiting for done to come back
		bs_wr_resp,                                 // write response pending
		bs_rd_resp                                  // read response pending
	} bridge_state_e;

	// PLL model FSM
	typedef enum logic {
		ms_idle,
		ms_busy                                     // DRP access in flight
	} model_state_e;

endpackage

//--- verilog/drp_if.sv
//************************************************************
// raw DRP port between the port block and the PLL
//************************************************************
`timescale 1ns/1ps

interface drp_if;

	logic                                den;    // one-cycle access strobe
	logic                                dwe;    // write when high, sampled with den
	logic [pll_cfg_pkg::drp_addr_w-1:0]  daddr;  // register address
	logic [pll_cfg_pkg::drp_data_w-1:0]  di;     // write data into the PLL
	logic [pll_cfg_pkg::drp_data_w-1:0]  dout;   // DO, read data out of the PLL
	logic                                drdy;   // one-cycle ready, dout valid with it

	// requester side
	modport port (output den, dwe, daddr, di, input dout, drdy);

	// PLL side
	modport pll (input den, dwe, daddr, di, output dout, drdy);

endinterface

//--- verilog/pll_cfg_if.sv
//************************************************************
// go/done request channel from the AXI bridge to the DRP port
//************************************************************
`timescale 1ns/1ps

interface pll_cfg_if;

	logic                                go;     // level request, held until done returns
	logic                                write;  // access direction
	logic [pll_cfg_pkg::drp_addr_w-1:0]  addr;   // DRP register address
	logic [pll_cfg_pkg::drp_data_w-1:0]  wdata;  // write data
	logic                                done;   // low after den, high after drdy
	logic [pll_cfg_pkg::drp_data_w-1:0]  rdata;  // read data latched at drdy

	// bridge drives the request
	modport bridge (output go, write, addr, wdata, input done, rdata);

	// port block answers
	modport port (input go, write, addr, wdata, output done, rdata);

endinterface

//--- verilog/axil_drp_bridge.sv
//************************************************************
// AXI4-Lite slave, address and strobe checks, DRP request FSM
//************************************************************
`timescale 1ns/1ps

module axil_drp_bridge (
	input  logic                                   drp_clk,
	input  logic                                   reset,
	input  logic [pll_cfg_pkg::axi_addr_w-1:0]     awaddr,
	input  logic                                   awvalid,
	output logic                                   awready,
	input  logic [pll_cfg_pkg::axi_data_w-1:0]     wdata,
	input  logic [pll_cfg_pkg::axi_data_w/8-1:0]   wstrb,
	input  logic                                   wvalid,
	output logic                                   wready,
	output logic [1:0]                             bresp,
	output logic                                   bvalid,
	input  logic                                   bready,
	input  logic [pll_cfg_pkg::axi_addr_w-1:0]     araddr,
	input  logic                                   arvalid,
	output logic                                   arready,
	output logic [pll_cfg_pkg::axi_data_w-1:0]     rdata,
	output logic [1:0]                             rresp,
	output logic                                   rvalid,
	input  logic                                   rready,
	pll_cfg_if.bridge                              cfg
);

	pll_cfg_pkg::bridge_state_e state;
	logic                                 accept_en;  // idle and free to take an access
	logic                                 wr_hs;      // aw and w taken together
	logic                                 rd_hs;      // ar taken
	logic [pll_cfg_pkg::drp_addr_w-1:0]   wr_addr;    // word address of the write
	logic [pll_cfg_pkg::drp_addr_w-1:0]   rd_addr;
	logic                                 wr_bad;     // reserved address or partial strobe
	logic                                 rd_bad;

	// a write needs both channels at once, a write address blocks reads
	assign awready = accept_en && awvalid && wvalid;
	assign wready  = accept_en && awvalid && wvalid;
	assign arready = accept_en && !awvalid;
	assign wr_hs   = awvalid && wvalid && awready;
	assign rd_hs   = arvalid && arready;

	assign wr_addr = awaddr[pll_cfg_pkg::axi_addr_w-1:2];
	assign rd_addr = araddr[pll_cfg_pkg::axi_addr_w-1:2];
	assign wr_bad  = (wr_addr > pll_cfg_pkg::drp_last_addr) || (wstrb[1:0] != 2'b11);
	assign rd_bad  = rd_addr > pll_cfg_pkg::drp_last_addr;

	always_ff @(posedge drp_clk) begin
		if (reset) begin
			state     <= pll_cfg_pkg::bs_idle;
			accept_en <= 1'b0;                      // readies stay low one cycle
			cfg.go    <= 1'b0;
			bvalid    <= 1'b0;
			rvalid    <= 1'b0;
		end else begin
			case (state)
				pll_cfg_pkg::bs_idle: begin
					if (wr_hs) begin
						accept_en <= 1'b0;
						cfg.write <= 1'b1;
						cfg.addr  <= wr_addr;
						cfg.wdata <= wdata[pll_cfg_pkg::drp_data_w-1:0];
						if (wr_bad) begin
							bresp  <= pll_cfg_pkg::slverr;  // refused, no DRP access
							bvalid <= 1'b1;
							state  <= pll_cfg_pkg::bs_wr_resp;
						end else begin
							cfg.go <= 1'b1;
							state  <= pll_cfg_pkg::bs_req_clr;
						end
					end else if (rd_hs) begin
						accept_en <= 1'b0;
						cfg.write <= 1'b0;
						cfg.addr  <= rd_addr;
						if (rd_bad) begin
							rresp  <= pll_cfg_pkg::slverr;
							rdata  <= '0;                    // refused reads return zero
							rvalid <= 1'b1;
							state  <= pll_cfg_pkg::bs_rd_resp;
						end else begin
							cfg.go <= 1'b1;
							state  <= pll_cfg_pkg::bs_req_clr;
						end
					end else begin
						accept_en <= 1'b1;
					end
				end
				pll_cfg_pkg::bs_req_clr: begin
					if (!cfg.done) state <= pll_cfg_pkg::bs_req_done;  // den has landed
				end
				pll_cfg_pkg::bs_req_done: begin
					if (cfg.done) begin                  // drdy seen by the port
						cfg.go <= 1'b0;
						if (cfg.write) begin
							bresp  <= pll_cfg_pkg::okay;
							bvalid <= 1'b1;
							state  <= pll_cfg_pkg::bs_wr_resp;
						end else begin
							rresp  <= pll_cfg_pkg::okay;
							rdata  <= {{(pll_cfg_pkg::axi_data_w-pll_cfg_pkg::drp_data_w){1'b0}},
								cfg.rdata};
							rvalid <= 1'b1;
							state  <= pll_cfg_pkg::bs_rd_resp;
						end
					end
				end
				pll_cfg_pkg::bs_wr_resp: begin
					if (bready) begin                    // hold until the master takes it
						bvalid    <= 1'b0;
						accept_en <= 1'b1;
						state     <= pll_cfg_pkg::bs_idle;
					end
				end
				pll_cfg_pkg::bs_rd_resp: begin
					if (rready) begin
						rvalid    <= 1'b0;
						accept_en <= 1'b1;
						state     <= pll_cfg_pkg::bs_idle;
					end
				end
				default: state <= pll_cfg_pkg::bs_idle;
			endcase
		end
	end

	// go drops only once done has been low for a whole DRP access and is back
	a_go_held: assert property (@(posedge drp_clk) disable iff (reset)
		$fell(cfg.go) |-> $past(cfg.done) && !$past(cfg.done, 2)
			&& !$past(cfg.done, pll_cfg_pkg::drp_lat_base + 1))
		else $error("go dropped before the DRP access finished");

endmodule

//--- verilog/pll_drp_port.sv
//************************************************************
// DRP request port, go edge to den pulse, done flag, read latch
//************************************************************
`timescale 1ns/1ps

module pll_drp_port (
	input  logic     drp_clk,
	input  logic     reset,
	pll_cfg_if.port  cfg,
	drp_if.port      drp
);

	logic go_q;                                     // go delayed one cycle

	// request fields go straight to the DRP, the bridge holds them stable
	assign drp.dwe   = cfg.write;
	assign drp.daddr = cfg.addr;
	assign drp.di    = cfg.wdata;

	// enable pulse on the rising edge of go
	always_ff @(posedge drp_clk) begin
		if (reset) begin
			go_q    <= 1'b0;
			drp.den <= 1'b0;
		end else begin
			go_q    <= cfg.go;
			drp.den <= cfg.go && !go_q;             // single cycle per request
		end
	end

	// done drops after den, comes back with drdy
	always_ff @(posedge drp_clk) begin
		if (reset) begin
			cfg.done <= 1'b0;
		end else if (drp.drdy) begin
			cfg.done <= 1'b1;
		end else if (drp.den) begin
			cfg.done <= 1'b0;
		end
	end

	// read data captured in the ready cycle
	always_ff @(posedge drp_clk) begin
		if (drp.drdy) cfg.rdata <= drp.dout;
	end

	// done is cleared the cycle after den and the PLL needs at least
	// drp_lat_base cycles, so a ready arriving on a high done is a stray one
	a_drdy_pending: assert property (@(posedge drp_clk) disable iff (reset)
		drp.drdy |-> !cfg.done)
		else $error("drdy without an outstanding den");

endmodule

//--- verilog/pll_drp_model.sv
//************************************************************
// behavioural PLL, DRP register space, address based ready latency
// and lock indication dropping after each write
//************************************************************
`timescale 1ns/1ps

module pll_drp_model (
	input  logic  drp_clk,
	input  logic  reset,
	output logic  locked,
	drp_if.pll    drp
);

	localparam int num_regs = 2 ** pll_cfg_pkg::drp_addr_w;

	pll_cfg_pkg::model_state_e            state;
	logic [pll_cfg_pkg::lat_cnt_w-1:0]    lat_cnt;    // cycles left before drdy
	logic [pll_cfg_pkg::drp_addr_w-1:0]   op_addr;    // access captured at den
	logic                                 op_write;
	logic [pll_cfg_pkg::drp_data_w-1:0]   op_data;
	logic [pll_cfg_pkg::drp_data_w-1:0]   regs [num_regs];
	logic [pll_cfg_pkg::lock_cnt_w-1:0]   lock_cnt;   // relock countdown

	// DRP access engine
	always_ff @(posedge drp_clk) begin
		if (reset) begin
			state    <= pll_cfg_pkg::ms_idle;
			drp.drdy <= 1'b0;
			for (int i = 0; i < num_regs; i++) regs[i] <= '0;  // PLL comes up blank
		end else begin
			drp.drdy <= 1'b0;                       // ready is a pulse
			case (state)
				pll_cfg_pkg::ms_idle: begin
					if (drp.den) begin
						state    <= pll_cfg_pkg::ms_busy;
						op_addr  <= drp.daddr;
						op_write <= drp.dwe;
						op_data  <= drp.di;
						// two cycles go to capture and the drdy register
						lat_cnt  <= pll_cfg_pkg::lat_cnt_w'(pll_cfg_pkg::drp_lat_base - 2
							+ drp.daddr[1:0]);
					end
				end
				pll_cfg_pkg::ms_busy: begin
					if (lat_cnt == '0) begin
						drp.drdy <= 1'b1;
						drp.dout <= regs[op_addr];       // old value on a write
						if (op_write) regs[op_addr] <= op_data;  // commit with drdy
						state    <= pll_cfg_pkg::ms_idle;
					end else begin
						lat_cnt <= lat_cnt - 1'b1;
					end
				end
				default: state <= pll_cfg_pkg::ms_idle;
			endcase
		end
	end

	// lock drops the cycle after a write's drdy and returns after the hold time
	always_ff @(posedge drp_clk) begin
		if (reset) begin
			lock_cnt <= pll_cfg_pkg::lock_cnt_w'(pll_cfg_pkg::lock_hold_cycles - 1);
			locked   <= 1'b0;
		end else if (drp.drdy && op_write) begin
			lock_cnt <= pll_cfg_pkg::lock_cnt_w'(pll_cfg_pkg::lock_hold_cycles - 1);
			locked   <= 1'b0;                       // reconfigured, relocking
		end else if (lock_cnt != '0) begin
			lock_cnt <= lock_cnt - 1'b1;
		end else begin
			locked <= 1'b1;
		end
	end

	// requester must wait for drdy before the next enable
	a_den_idle: assert property (@(posedge drp_clk) disable iff (reset)
		drp.den |-> state == pll_cfg_pkg::ms_idle)
		else $error("den issued while a DRP access is in flight");

endmodule

//--- verilog/pll_ctrl_top.sv
//************************************************************
// PLL config top, AXI4-Lite bridge, DRP port and PLL model
//************************************************************
`timescale 1ns/1ps

module pll_ctrl_top (
	input  logic                                   drp_clk,
	input  logic                                   reset,
	input  logic [pll_cfg_pkg::axi_addr_w-1:0]     awaddr,
	input  logic                                   awvalid,
	output logic                                   awready,
	input  logic [pll_cfg_pkg::axi_data_w-1:0]     wdata,
	input  logic [pll_cfg_pkg::axi_data_w/8-1:0]   wstrb,
	input  logic                                   wvalid,
	output logic                                   wready,
	output logic [1:0]                             bresp,
	output logic                                   bvalid,
	input  logic                                   bready,
	input  logic [pll_cfg_pkg::axi_addr_w-1:0]     araddr,
	input  logic                                   arvalid,
	output logic                                   arready,
	output logic [pll_cfg_pkg::axi_data_w-1:0]     rdata,
	output logic [1:0]                             rresp,
	output logic                                   rvalid,
	input  logic                                   rready,
	output logic                                   locked
);

	pll_cfg_if cfg ();                              // bridge to port requests
	drp_if     drp ();                              // port to PLL

	axil_drp_bridge i_bridge (
		.drp_clk (drp_clk),
		.reset   (reset),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready),
		.cfg     (cfg.bridge)
	);

	pll_drp_port i_port (.drp_clk(drp_clk), .reset(reset), .cfg(cfg.port), .drp(drp.port));

	pll_drp_model i_pll (.drp_clk(drp_clk), .reset(reset), .locked(locked), .drp(drp.pll));

endmodule

//--- test/tb_pll_ctrl.sv
//************************************************************
// testbench for the PLL config top, AXI4-Lite access task,
// LCG response delays, access list replay and lock checks
//************************************************************
`timescale 1ns/1ps

module tb_pll_ctrl;

	localparam int max_recs       = 64;                 // room in the access list
	localparam int access_timeout = 64;                 // cycles allowed per AXI phase
	localparam int lock_timeout   = pll_cfg_pkg::lock_hold_cycles + 16;

	logic                                   drp_clk;
	logic                                   reset;
	logic [pll_cfg_pkg::axi_addr_w-1:0]     awaddr;
	logic                                   awvalid;
	logic                                   awready;
	logic [pll_cfg_pkg::axi_data_w-1:0]     wdata;
	logic [pll_cfg_pkg::axi_data_w/8-1:0]   wstrb;
	logic                                   wvalid;
	logic                                   wready;
	logic [1:0]                             bresp;
	logic                                   bvalid;
	logic                                   bready;
	logic [pll_cfg_pkg::axi_addr_w-1:0]     araddr;
	logic                                   arvalid;
	logic                                   arready;
	logic [pll_cfg_pkg::axi_data_w-1:0]     rdata;
	logic [1:0]                             rresp;
	logic                                   rvalid;
	logic                                   rready;
	logic                                   locked;

	logic [31:0] vec [0:max_recs*5-1];              // five words per access
	logic [31:0] lcg_state;
	logic        saw_unlock;                        // locked seen low during an access
	int          value_errors;
	int          other_errors;
	int          timeouts;

	pll_ctrl_top i_dut (.*);

	always #5 drp_clk = ~drp_clk;                   // 100 MHz

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic addr_taken(input logic is_write);
		return is_write ? (awready && wready) : arready;
	endfunction

	function automatic logic resp_valid(input logic is_write);
		return is_write ? bvalid : rvalid;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("error %s got %h expected %h", name, got, exp);
		value_errors++;
	endtask

	task automatic wait_locked_high();
		int cnt;
		cnt = 0;
		while (!locked && cnt < lock_timeout) begin
			@(negedge drp_clk);
			cnt++;
		end
		if (!locked) begin
			$display("timeout: locked did not come back high within %0d cycles", lock_timeout);
			timeouts++;
		end
	endtask

	// one AXI access, address phase, response wait, random ready delay
	task automatic axi_access(input logic is_write,
			input logic [pll_cfg_pkg::axi_addr_w-1:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output logic [31:0] rd, output logic [1:0] resp,
			output logic ok);
		int cnt;
		int delay;
		ok   = 1'b0;
		rd   = '0;
		resp = 2'b11;
		@(negedge drp_clk);
		if (is_write) begin
			awaddr  = addr;
			wdata   = data;
			wstrb   = strb;
			awvalid = 1'b1;
			wvalid  = 1'b1;                         // both channels together
		end else begin
			araddr  = addr;
			arvalid = 1'b1;
		end
		cnt = 0;
		#1;                                         // let the combinational readies settle
		while (!addr_taken(is_write) && cnt < access_timeout) begin
			@(negedge drp_clk);
			#1;
			cnt++;
		end
		@(negedge drp_clk);                         // transfer took place on the posedge
		awvalid = 1'b0;
		wvalid  = 1'b0;
		arvalid = 1'b0;
		if (cnt >= access_timeout) begin
			$display("timeout: access to address %h was never accepted", addr);
			timeouts++;
			return;
		end
		cnt = 0;
		while (!resp_valid(is_write) && cnt < access_timeout) begin
			if (!locked) saw_unlock = 1'b1;
			@(negedge drp_clk);
			cnt++;
		end
		if (!resp_valid(is_write)) begin
			$display("timeout: no response for the access to address %h", addr);
			timeouts++;
			return;
		end
		resp  = is_write ? bresp : rresp;
		rd    = is_write ? 32'h0 : rdata;
		delay = int'(next_rand() >> 29);            // 0 to 7 cycles of back-pressure
		// the other kind of access is offered meanwhile and must not be taken
		if (is_write) begin
			arvalid = 1'b1;
		end else begin
			awvalid = 1'b1;
			wvalid  = 1'b1;
		end
		for (int i = 0; i < delay; i++) begin
			#1;
			if (!locked) saw_unlock = 1'b1;
			if (is_write && bresp !== resp) report_mismatch("bresp", {30'b0, bresp}, {30'b0, resp});
			if (!is_write && rresp !== resp) report_mismatch("rresp", {30'b0, rresp}, {30'b0, resp});
			if (!is_write && rdata !== rd) report_mismatch("rdata", rdata, rd);
			if (!is_write && awready !== 1'b0) report_mismatch("awready", {31'b0, awready}, 32'h0);
			if (!is_write && wready !== 1'b0) report_mismatch("wready", {31'b0, wready}, 32'h0);
			if (is_write && arready !== 1'b0) report_mismatch("arready", {31'b0, arready}, 32'h0);
			@(negedge drp_clk);
			if (resp_valid(is_write) !== 1'b1)
				report_mismatch(is_write ? "bvalid" : "rvalid", 32'h0, 32'h1);
		end
		awvalid = 1'b0;
		wvalid  = 1'b0;
		arvalid = 1'b0;
		bready  = is_write;
		rready  = !is_write;
		@(negedge drp_clk);
		bready = 1'b0;
		rready = 1'b0;
		if (resp_valid(is_write) !== 1'b0)
			report_mismatch(is_write ? "bvalid" : "rvalid", 32'h1, 32'h0);
		ok = 1'b1;
	endtask

	initial begin
		int                                 rec;
		logic [31:0]                        op;
		logic [pll_cfg_pkg::axi_addr_w-1:0] addr;
		logic [31:0]                        data;
		logic [31:0]                        exp_rdata;
		logic [1:0]                         exp_resp;
		logic [31:0]                        got_rdata;
		logic [1:0]                         got_resp;
		logic                               ok;
		logic                               expect_unlock;

		drp_clk      = 1'b0;
		reset        = 1'b1;
		awaddr       = '0;
		awvalid      = 1'b0;
		wdata        = '0;
		wstrb        = '0;
		wvalid       = 1'b0;
		bready       = 1'b0;
		araddr       = '0;
		arvalid      = 1'b0;
		rready       = 1'b0;
		lcg_state    = 32'h2d7f_86ba;
		saw_unlock   = 1'b0;
		value_errors = 0;
		other_errors = 0;
		timeouts     = 0;
		$readmemh("test/pll_ctrl_input.txt", vec);
		if ($isunknown(vec[0])) begin
			$display("the access list test/pll_ctrl_input.txt could not be read");
			other_errors++;
		end

		repeat (16) @(negedge drp_clk);
		reset = 1'b0;
		#1;
		if (bvalid !== 1'b0) report_mismatch("bvalid", {31'b0, bvalid}, 32'h0);
		if (rvalid !== 1'b0) report_mismatch("rvalid", {31'b0, rvalid}, 32'h0);
		if (arready !== 1'b0) report_mismatch("arready", {31'b0, arready}, 32'h0);
		if (locked !== 1'b0) report_mismatch("locked", {31'b0, locked}, 32'h0);
		wait_locked_high();                         // first lock after reset

		rec = 0;
		while (rec < max_recs && vec[rec*5] !== 32'hf) begin
			op            = vec[rec*5];
			addr          = vec[rec*5+1][pll_cfg_pkg::axi_addr_w-1:0];
			data          = vec[rec*5+2];
			exp_rdata     = vec[rec*5+3];
			exp_resp      = vec[rec*5+4][1:0];
			expect_unlock = (op != 32'h0) && (exp_resp == 2'b00);  // accepted write relocks
			saw_unlock    = 1'b0;
			case (op)
				32'h0: axi_access(1'b0, addr, data, 4'h0, got_rdata, got_resp, ok);
				32'h1: axi_access(1'b1, addr, data, 4'hf, got_rdata, got_resp, ok);
				32'h2: axi_access(1'b1, addr, data, 4'h1, got_rdata, got_resp, ok);
				32'h3: axi_access(1'b1, addr, data, 4'he, got_rdata, got_resp, ok);
				default: begin
					$display("unknown operation %0h in access list record %0d", op, rec);
					other_errors++;
					ok = 1'b0;
				end
			endcase
			if (ok) begin
				if (op == 32'h0 && got_resp !== exp_resp)
					report_mismatch("rresp", {30'b0, got_resp}, {30'b0, exp_resp});
				if (op == 32'h0 && got_rdata !== exp_rdata)
					report_mismatch("rdata", got_rdata, exp_rdata);
				if (op != 32'h0 && got_resp !== exp_resp)
					report_mismatch("bresp", {30'b0, got_resp}, {30'b0, exp_resp});
				if (expect_unlock && !saw_unlock) begin
					$display("locked never dropped after the write to address %h", addr);
					other_errors++;
				end
				if (!expect_unlock && saw_unlock) begin
					$display("locked dropped during the access to address %h", addr);
					other_errors++;
				end
				if (expect_unlock) wait_locked_high();
			end
			rec++;
		end

		$display("accesses %0d, value errors %0d, other errors %0d, timeouts %0d",
			rec, value_errors, other_errors, timeouts);
		if (value_errors == 0 && other_errors == 0 && timeouts == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- test/pll_ctrl_input.txt
// columns: op, byte address, write data, expected read data, expected response (hex)
// op 0 read, 1 write wstrb f, 2 write wstrb 1, 3 write wstrb e, f ends the list
// registers come up blank
0 000 00000000 00000000 0
0 0a4 00000000 00000000 0
0 13c 00000000 00000000 0
// writes covering DRP address bits 1:0 of 0 to 3, upper half dropped
1 020 dead1234 00000000 0
1 024 0000beef 00000000 0
1 028 ffff0001 00000000 0
1 02c 12345678 00000000 0
1 13c a5a5c3c3 00000000 0
0 020 00000000 00001234 0
0 024 00000000 0000beef 0
0 028 00000000 00000001 0
0 02c 00000000 00005678 0
0 13c 00000000 0000c3c3 0
// second write to the same register replaces the first
1 020 5555aaaa 00000000 0
0 020 00000000 0000aaaa 0
// reserved addresses above DRP 0x4f
1 140 0000ffff 00000000 2
0 140 00000000 00000000 2
1 1fc 00001111 00000000 2
0 1fc 00000000 00000000 2
0 13c 00000000 0000c3c3 0
// partial strobes are refused and leave the register alone
2 024 00007777 00000000 2
3 028 00008888 00000000 2
0 024 00000000 0000beef 0
0 028 00000000 00000001 0
0 0a4 00000000 00000000 0
f 000 00000000 00000000 0

//--- flist.f
verilog/pll_cfg_pkg.sv
verilog/drp_if.sv
verilog/pll_cfg_if.sv
verilog/axil_drp_bridge.sv
verilog/pll_drp_port.sv
verilog/pll_drp_model.sv
verilog/pll_ctrl_top.sv
test/tb_pll_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# build the PLL config testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_pll_ctrl -f flist.f || exit 1
out=$(./obj_dir/Vtb_pll_ctrl)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TB PASSED" && echo "simulation ok" || { echo "simulation not ok"; exit 1; }
